// ==== design/frame_buffer.sv ====
// frame_buffer module, 128 x 12 bit memory with one write port and a registered read port
`timescale 1ns/100ps
`default_nettype none

`include "vision_defines.svh"

module frame_buffer (
  input  logic                    clk,
  input  logic                    wr_en,
  input  logic [`FB_ADDR_W-1:0]   wr_addr,
  input  logic [`FB_ADDR_W-1:0]   rd_addr,
  input  vision_pkg::pix444_t     wr_pixel,
  output vision_pkg::pix444_t     rd_pixel
);
  import vision_pkg::*;

  // one RGB444 word per active pixel
  pix444_t mem [`FB_DEPTH];

  // write side, camera pixels
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_pixel;
    end
  end

  // read side, one cycle latency
  // same address in the same cycle gives the old word
  always_ff @(posedge clk) begin
    rd_pixel <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== design/ov7670_capture.sv ====
// ov7670_capture module pairing camera bytes into RGB444 pixels with a write address counter
`timescale 1ns/100ps
`default_nettype none

`include "vision_defines.svh"

module ov7670_capture (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cam_vsync,
  input  logic                    cam_href,
  input  logic [7:0]              cam_data,
  output logic                    wr_en,
  output logic [`FB_ADDR_W-1:0]   wr_addr,
  output vision_pkg::pix444_t     wr_pixel
);
  import vision_pkg::*;

  // 0 waits for the red byte, 1 waits for the green/blue byte
  logic                byte_phase;
  logic [3:0]          red_hold;
  // saturates at FB_DEPTH, which blocks further writes
  logic [`FB_ADDR_W:0] addr_cnt;
  logic                pair_done;

  assign pair_done = cam_href && byte_phase;

  // byte phase and write address, both restart on vsync
  always_ff @(posedge clk) begin
    if (reset || cam_vsync) begin
      byte_phase <= 1'b0;
      addr_cnt   <= '0;
    end else if (cam_href) begin
      byte_phase <= ~byte_phase;
      if (byte_phase && (addr_cnt < `FB_DEPTH)) begin
        addr_cnt <= addr_cnt + 1'b1;
      end
    end else begin
      // a new line always starts on a first byte
      byte_phase <= 1'b0;
    end
  end

  // first byte carries red in its low nibble
  always_ff @(posedge clk) begin
    if (cam_href && !byte_phase) begin
      red_hold <= cam_data[3:0];
    end
  end

  // one cycle strobe per completed pair, dropped past the buffer end
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= !cam_vsync && pair_done && (addr_cnt < `FB_DEPTH);
    end
  end

  // second byte is green high nibble, blue low nibble
  always_ff @(posedge clk) begin
    if (pair_done) begin
      wr_addr  <= addr_cnt[`FB_ADDR_W-1:0];
      wr_pixel <= '{r: red_hold, g: cam_data[7:4], b: cam_data[3:0]};
    end
  end

  // pixels need two bytes, so strobes can never be back to back
  a_wr_spaced : assert property (
    @(posedge clk) disable iff (reset) wr_en |=> !wr_en
  );

endmodule

`default_nettype wire

// ==== design/scan_timing.sv ====
// scan_timing module with raster counters, sync levels and frame buffer read address
`timescale 1ns/100ps
`default_nettype none

`include "vision_defines.svh"

module scan_timing (
  input  logic                    clk,
  input  logic                    reset,
  output vision_pkg::scan_pos_t   pos,
  output logic [`FB_ADDR_W-1:0]   rd_addr
);
  import vision_pkg::*;

  logic [4:0]          h_cnt;
  logic [3:0]          v_cnt;
  // one bit wider than the address so an overrun is visible
  logic [`FB_ADDR_W:0] rd_cnt;
  logic                line_end;
  logic                frame_end;

  assign line_end  = (h_cnt == `H_TOTAL - 1);
  assign frame_end = line_end && (v_cnt == `V_TOTAL - 1);

  // free running column and line counters
  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      if (frame_end) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // position, active flag and sync levels straight from the counters
  always_comb begin
    pos.x      = h_cnt;
    pos.y      = v_cnt;
    pos.active = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
    pos.hsync  = (h_cnt >= `H_SYNC_START) && (h_cnt < `H_SYNC_END);
    pos.vsync  = (v_cnt == `V_SYNC_LINE);
  end

  // read address counts active positions since frame start
  // so it always equals y * H_ACTIVE + x on an active position
  always_ff @(posedge clk) begin
    if (reset || frame_end) begin
      rd_cnt <= '0;
    end else if (pos.active) begin
      rd_cnt <= rd_cnt + 1'b1;
    end
  end

  assign rd_addr = rd_cnt[`FB_ADDR_W-1:0];

  // the frame must never scan past the end of the buffer
  a_rd_in_range : assert property (
    @(posedge clk) disable iff (reset) pos.active |-> (rd_cnt < `FB_DEPTH)
  );

endmodule

`default_nettype wire

// ==== design/target_classifier.sv ====
// target_classifier module, FSM counting orange pixels per region and deciding the direction
`timescale 1ns/100ps
`default_nettype none

`include "vision_defines.svh"

module target_classifier (
  input  logic                     clk,
  input  logic                     reset,
  input  vision_pkg::scan_pos_t    out_pos,
  input  logic                     out_orange,
  output logic                     frame_done,
  output logic                     orange_detected,
  output vision_pkg::direction_e   direction
);
  import vision_pkg::*;

  classifier_state_e     state;
  // each region holds at most FB_DEPTH pixels
  logic [`FB_ADDR_W:0]   left_cnt;
  logic [`FB_ADDR_W:0]   center_cnt;
  logic [`FB_ADDR_W:0]   right_cnt;
  logic [`FB_ADDR_W+1:0] total_cnt;
  logic                  first_pix;
  logic                  last_pix;
  logic                  count_en;
  direction_e            dir_next;

  // frame corners as seen at the finder output
  assign first_pix = out_pos.active && (out_pos.x == 0) && (out_pos.y == 0);
  assign last_pix  = out_pos.active && (out_pos.x == `H_ACTIVE - 1) &&
                     (out_pos.y == `V_ACTIVE - 1);

  // the first pixel is counted on the way into ST_SCAN
  assign count_en = out_orange &&
                    ((state == ST_SCAN) || ((state == ST_WAIT_FRAME) && first_pix));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_WAIT_FRAME;
    end else begin
      case (state)
        ST_WAIT_FRAME: if (first_pix) state <= ST_SCAN;
        ST_SCAN:       if (last_pix) state <= ST_DECIDE;
        default:       state <= ST_WAIT_FRAME;
      endcase
    end
  end

  // region counters, cleared as the FSM leaves ST_DECIDE
  always_ff @(posedge clk) begin
    if (reset || (state == ST_DECIDE)) begin
      left_cnt   <= '0;
      center_cnt <= '0;
      right_cnt  <= '0;
    end else if (count_en) begin
      if (out_pos.x < `LEFT_END) begin
        left_cnt <= left_cnt + 1'b1;
      end else if (out_pos.x >= `RIGHT_START) begin
        right_cnt <= right_cnt + 1'b1;
      end else begin
        center_cnt <= center_cnt + 1'b1;
      end
    end
  end

  // largest region wins, ties go to centre then left
  always_comb begin
    total_cnt = {1'b0, left_cnt} + {1'b0, center_cnt} + {1'b0, right_cnt};
    if (total_cnt < `DETECT_MIN) begin
      dir_next = DIR_NONE;
    end else if ((center_cnt >= left_cnt) && (center_cnt >= right_cnt)) begin
      dir_next = DIR_CENTER;
    end else if (left_cnt >= right_cnt) begin
      dir_next = DIR_LEFT;
    end else begin
      dir_next = DIR_RIGHT;
    end
  end

  // results update together with the done pulse and then hold
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_done      <= 1'b0;
      orange_detected <= 1'b0;
      direction       <= DIR_NONE;
    end else begin
      frame_done <= (state == ST_DECIDE);
      if (state == ST_DECIDE) begin
        orange_detected <= (total_cnt >= `DETECT_MIN);
        direction       <= dir_next;
      end
    end
  end

  // one pulse per frame, never stretched
  a_done_pulse : assert property (
    @(posedge clk) disable iff (reset) frame_done |=> !frame_done
  );

endmodule

`default_nettype wire

// ==== design/target_finder.sv ====
// target_finder module with colour expansion, orange test, highlighting and blanking
`timescale 1ns/100ps
`default_nettype none

`include "vision_defines.svh"

module target_finder (
  input  logic                     clk,
  input  logic                     reset,
  input  vision_pkg::scan_pos_t    pos,
  input  vision_pkg::pix444_t      rd_pixel,
  output vision_pkg::scan_pos_t    out_pos,
  output vision_pkg::rgb_pixel_t   out_pixel,
  output logic                     out_orange
);
  import vision_pkg::*;

  // position delayed to line up with the buffer read
  scan_pos_t  pos_d;
  logic       is_orange;
  rgb_pixel_t expanded;

  always_ff @(posedge clk) begin
    if (reset) begin
      pos_d <= '0;
    end else begin
      pos_d <= pos;
    end
  end

  // orange rule on the raw nibbles, only inside the picture
  always_comb begin
    is_orange = pos_d.active &&
                (rd_pixel.r >= `ORANGE_R_MIN) &&
                (rd_pixel.g >= `ORANGE_G_MIN) &&
                (rd_pixel.g <= `ORANGE_G_MAX) &&
                (rd_pixel.b <= `ORANGE_B_MAX);
    // nibble copied into both halves
    expanded.r = {rd_pixel.r, rd_pixel.r};
    expanded.g = {rd_pixel.g, rd_pixel.g};
    expanded.b = {rd_pixel.b, rd_pixel.b};
  end

  // second stage, position and flag
  always_ff @(posedge clk) begin
    if (reset) begin
      out_pos    <= '0;
      out_orange <= 1'b0;
    end else begin
      out_pos    <= pos_d;
      out_orange <= is_orange;
    end
  end

  // black outside the picture, hits shown as pure red
  always_ff @(posedge clk) begin
    if (!pos_d.active) begin
      out_pixel <= '0;
    end else if (is_orange) begin
      out_pixel <= '{r: 8'hff, g: 8'h00, b: 8'h00};
    end else begin
      out_pixel <= expanded;
    end
  end

endmodule

`default_nettype wire

// ==== design/vision_defines.svh ====
// frame geometry, sync positions, region bounds, colour thresholds and detection minimum
`ifndef VISION_DEFINES_SVH
`define VISION_DEFINES_SVH

// horizontal timing in clocks per line
`define H_ACTIVE      16
`define H_TOTAL       24
// hsync high from start up to but not including end
`define H_SYNC_START  18
`define H_SYNC_END    21

// vertical timing in lines per frame
`define V_ACTIVE      8
`define V_TOTAL       11
// vsync high for this whole line
`define V_SYNC_LINE   9

// frame buffer holds exactly one active frame
`define FB_DEPTH      128
`define FB_ADDR_W     7

// left is x below LEFT_END, right is x from RIGHT_START, centre in between
`define LEFT_END      5
`define RIGHT_START   11

// nibble thresholds of the orange rule
`define ORANGE_R_MIN  12
`define ORANGE_G_MIN  4
`define ORANGE_G_MAX  10
`define ORANGE_B_MAX  4

// fewest orange pixels per frame that count as a target
`define DETECT_MIN    4

`endif

// ==== design/vision_pkg.sv ====
// vision_pkg with pixel structs, scan position struct, direction and classifier state enums
`default_nettype none

package vision_pkg;

  // camera pixel and frame buffer word, RGB444
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pix444_t;

  // display pixel, 8 bits per channel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_pixel_t;

  // raster position that rides along with each pixel
  typedef struct packed {
    logic [4:0] x;
    logic [3:0] y;
    logic       active;
    logic       hsync;
    logic       vsync;
  } scan_pos_t;

  // where the target sits in the picture
  typedef enum logic [1:0] {
    DIR_NONE,
    DIR_LEFT,
    DIR_CENTER,
    DIR_RIGHT
  } direction_e;

  // per-frame classifier FSM
  typedef enum logic [1:0] {
    ST_WAIT_FRAME,
    ST_SCAN,
    ST_DECIDE
  } classifier_state_e;

endpackage

`default_nettype wire

// ==== design/vision_top.sv ====
// vision_top module connecting capture, frame buffer, scan timing, finder and classifier
`timescale 1ns/100ps
`default_nettype none

`include "vision_defines.svh"

module vision_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cam_vsync,
  input  logic                     cam_href,
  input  logic [7:0]               cam_data,
  output logic                     vga_hsync,
  output logic                     vga_vsync,
  output logic                     vga_blank_n,
  output vision_pkg::rgb_pixel_t   vga_pixel,
  output logic                     frame_done,
  output logic                     orange_detected,
  output vision_pkg::direction_e   direction
);
  import vision_pkg::*;

  // camera to buffer
  logic                  wr_en;
  logic [`FB_ADDR_W-1:0] wr_addr;
  pix444_t               wr_pixel;
  // buffer to display
  scan_pos_t             scan_pos;
  logic [`FB_ADDR_W-1:0] rd_addr;
  pix444_t               rd_pixel;
  // finder to classifier and VGA pins
  scan_pos_t             out_pos;
  logic                  out_orange;

  ov7670_capture u_capture (
    .clk      (clk),
    .reset    (reset),
    .cam_vsync(cam_vsync),
    .cam_href (cam_href),
    .cam_data (cam_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_pixel (wr_pixel)
  );

  frame_buffer u_frame_buffer (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .rd_addr (rd_addr),
    .wr_pixel(wr_pixel),
    .rd_pixel(rd_pixel)
  );

  scan_timing u_scan_timing (
    .clk    (clk),
    .reset  (reset),
    .pos    (scan_pos),
    .rd_addr(rd_addr)
  );

  target_finder u_target_finder (
    .clk       (clk),
    .reset     (reset),
    .pos       (scan_pos),
    .rd_pixel  (rd_pixel),
    .out_pos   (out_pos),
    .out_pixel (vga_pixel),
    .out_orange(out_orange)
  );

  target_classifier u_classifier (
    .clk            (clk),
    .reset          (reset),
    .out_pos        (out_pos),
    .out_orange     (out_orange),
    .frame_done     (frame_done),
    .orange_detected(orange_detected),
    .direction      (direction)
  );

  // sync and blank come from the delayed position, aligned with the pixel
  assign vga_hsync   = out_pos.hsync;
  assign vga_vsync   = out_pos.vsync;
  assign vga_blank_n = out_pos.active;

endmodule

`default_nettype wire

// ==== dv/vision_tb.sv ====
// vision_tb testbench with LCG stimulus, frame model, compare tasks and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "vision_defines.svh"

module vision_tb;
  import vision_pkg::*;

  localparam int N_TESTS      = 13;
  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  // four display frames of 4 ns clocks per test plus room for reset
  localparam int WATCHDOG_NS  = N_TESTS * 4 * FRAME_CYCLES * 4 + 4000;

  logic       clk = 1'b0;
  logic       reset;
  logic       cam_vsync;
  logic       cam_href;
  logic [7:0] cam_data;
  logic       vga_hsync;
  logic       vga_vsync;
  logic       vga_blank_n;
  rgb_pixel_t vga_pixel;
  logic       frame_done;
  logic       orange_detected;
  direction_e direction;

  // reference copy of the frame buffer
  pix444_t     model [`FB_DEPTH];
  logic [31:0] rand_state = 32'hfc9d_6e45;
  int          errors = 0;
  int          errs_at_start;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       cur_name;

  vision_top uut (
    .clk            (clk),
    .reset          (reset),
    .cam_vsync      (cam_vsync),
    .cam_href       (cam_href),
    .cam_data       (cam_data),
    .vga_hsync      (vga_hsync),
    .vga_vsync      (vga_vsync),
    .vga_blank_n    (vga_blank_n),
    .vga_pixel      (vga_pixel),
    .frame_done     (frame_done),
    .orange_detected(orange_detected),
    .direction      (direction)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // upper bits only since the low LCG bits cycle quickly
  function automatic int rand_below(input int n);
    return int'(next_rand() >> 16) % n;
  endfunction

  function automatic logic is_orange(input pix444_t p);
    return (p.r >= `ORANGE_R_MIN) && (p.g >= `ORANGE_G_MIN) &&
           (p.g <= `ORANGE_G_MAX) && (p.b <= `ORANGE_B_MAX);
  endfunction

  // random colour outside the orange rule with blue pushed above the limit
  function automatic pix444_t rand_plain();
    logic [31:0] v;
    pix444_t     p;
    v = next_rand();
    p = pix444_t'(v[27:16]);
    if (is_orange(p)) begin
      p.b = 4'hf;
    end
    return p;
  endfunction

  // random colour inside every orange bound
  function automatic pix444_t rand_orange();
    logic [31:0] v;
    pix444_t     p;
    v = next_rand();
    p.r = 4'(`ORANGE_R_MIN + (v[31:24] % (16 - `ORANGE_R_MIN)));
    p.g = 4'(`ORANGE_G_MIN + (v[23:16] % (`ORANGE_G_MAX - `ORANGE_G_MIN + 1)));
    p.b = 4'(v[15:8] % (`ORANGE_B_MAX + 1));
    return p;
  endfunction

  // what the display should show for one stored pixel
  function automatic rgb_pixel_t expected_pixel(input pix444_t p);
    rgb_pixel_t e;
    if (is_orange(p)) begin
      e = '{r: 8'hff, g: 8'h00, b: 8'h00};
    end else begin
      e.r = {p.r, p.r};
      e.g = {p.g, p.g};
      e.b = {p.b, p.b};
    end
    return e;
  endfunction

  // per-region counts then the largest region with centre and left winning ties
  task automatic decide_frame(output logic det, output direction_e dir);
    int l = 0;
    int c = 0;
    int r = 0;
    int x;
    for (int a = 0; a < `FB_DEPTH; a++) begin
      x = a % `H_ACTIVE;
      if (is_orange(model[a])) begin
        if (x < `LEFT_END) begin
          l++;
        end else if (x >= `RIGHT_START) begin
          r++;
        end else begin
          c++;
        end
      end
    end
    det = (l + c + r) >= `DETECT_MIN;
    if (!det) begin
      dir = DIR_NONE;
    end else if (c >= l && c >= r) begin
      dir = DIR_CENTER;
    end else if (l >= r) begin
      dir = DIR_LEFT;
    end else begin
      dir = DIR_RIGHT;
    end
  endtask

  task automatic check_pixel(input string name, input rgb_pixel_t exp, input rgb_pixel_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_direction(input string name, input direction_e exp,
                                 input direction_e act);
    if (act !== exp) begin
      $display("mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  // plain colours with a quarter made orange on request
  task automatic fill_frame(input logic quarter_orange);
    for (int a = 0; a < `FB_DEPTH; a++) begin
      model[a] = rand_plain();
      if (quarter_orange && rand_below(4) == 0) begin
        model[a] = rand_orange();
      end
    end
  endtask

  // orange pixels at random rows in columns from x_lo up to x_hi
  task automatic add_orange(input int count, input int x_lo, input int x_hi);
    int x;
    int y;
    for (int i = 0; i < count; i++) begin
      x = x_lo + rand_below(x_hi - x_lo);
      y = rand_below(`V_ACTIVE);
      model[y * `H_ACTIVE + x] = rand_orange();
    end
  endtask

  // camera load with vsync first and one href burst per picture line
  // junk pixels and anything past the buffer come from the LCG rather than the model
  task automatic send_frame(input int n_pix, input logic junk);
    pix444_t     p;
    logic [31:0] v;
    @(posedge clk);
    #0.5;
    cam_vsync = 1'b1;
    cam_href  = 1'b0;
    repeat (2) @(posedge clk);
    #0.5;
    cam_vsync = 1'b0;
    for (int k = 0; k < n_pix; k++) begin
      v = next_rand();
      if (junk || k >= `FB_DEPTH) begin
        p = pix444_t'(v[23:12]);
      end else begin
        p = model[k];
      end
      // high nibble of the red byte is don't care
      @(posedge clk);
      #0.5;
      cam_href = 1'b1;
      cam_data = {v[31:28], p.r};
      @(posedge clk);
      #0.5;
      cam_data = {p.g, p.b};
      if ((k % `H_ACTIVE) == `H_ACTIVE - 1 || k == n_pix - 1) begin
        @(posedge clk);
        #0.5;
        cam_href = 1'b0;
        cam_data = 8'h00;
        // line gap that also lets the last write land
        repeat (3) @(posedge clk);
      end
    end
  endtask

  // one whole display frame from the end of vsync to the next vsync
  // sampled on the falling edge away from the edge that updates outputs
  task automatic check_frame(input string name);
    logic       exp_det;
    direction_e exp_dir;
    logic       prev_det;
    direction_e prev_dir;
    logic       prev_hsync = 1'b0;
    logic       active_seen = 1'b0;
    int         k = 0;
    int         run = 0;
    int         runs = 0;
    int         bad_runs = 0;
    int         hs_cnt = 0;
    int         done_cnt = 0;
    int         vs_len = 0;
    int         cyc = 0;
    int         last_cyc = 0;
    int         done_cyc = 0;
    decide_frame(exp_det, exp_dir);
    do @(negedge clk); while (!vga_vsync);
    while (vga_vsync) begin
      vs_len++;
      @(negedge clk);
    end
    prev_det = orange_detected;
    prev_dir = direction;
    while (!vga_vsync) begin
      if (vga_blank_n) begin
        // k-th active output pixel maps to model address k
        if (k < `FB_DEPTH) begin
          check_pixel($sformatf("%s pixel %0d", name, k), expected_pixel(model[k]), vga_pixel);
        end
        k++;
        run++;
        active_seen = 1'b1;
        last_cyc = cyc;
      end else begin
        // nothing but black outside the picture
        check_pixel($sformatf("%s blank pixel", name), '0, vga_pixel);
        if (run != 0) begin
          if (run != `H_ACTIVE) begin
            bad_runs++;
          end
          runs++;
          run = 0;
        end
      end
      // only hsync pulses that close an active line
      if (vga_hsync && !prev_hsync && active_seen) begin
        hs_cnt++;
        active_seen = 1'b0;
      end
      prev_hsync = vga_hsync;
      if (frame_done) begin
        done_cnt++;
        done_cyc = cyc;
        check_bit({name, " detected"}, exp_det, orange_detected);
        check_direction({name, " direction"}, exp_dir, direction);
      end else begin
        // results only move together with frame_done
        check_bit({name, " detected hold"}, prev_det, orange_detected);
        check_direction({name, " direction hold"}, prev_dir, direction);
      end
      prev_det = orange_detected;
      prev_dir = direction;
      cyc++;
      @(negedge clk);
    end
    check_count({name, " vsync cycles"}, `H_TOTAL, vs_len);
    check_count({name, " active cycles"}, `FB_DEPTH, k);
    check_count({name, " active runs"}, `V_ACTIVE, runs);
    check_count({name, " short runs"}, 0, bad_runs);
    check_count({name, " hsync pulses"}, `V_ACTIVE, hs_cnt);
    check_count({name, " frame_done pulses"}, 1, done_cnt);
    if (done_cnt == 1 && (done_cyc - last_cyc < 1 || done_cyc - last_cyc > 3)) begin
      $display("error: %s frame_done came %0d cycles after the last pixel",
               name, done_cyc - last_cyc);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_name = name;
    errs_at_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %-14s ok", cur_name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", cur_name, errors - errs_at_start);
    end
  endtask

  initial begin
    cam_vsync = 1'b0;
    cam_href  = 1'b0;
    cam_data  = 8'h00;
    reset     = 1'b1;
    repeat (3) @(posedge clk);
    #0.5;
    reset = 1'b0;

    start_test("reset_raster");
    @(negedge clk);
    check_bit("reset_raster frame_done", 1'b0, frame_done);
    check_bit("reset_raster detected", 1'b0, orange_detected);
    check_direction("reset_raster direction", DIR_NONE, direction);
    check_bit("reset_raster blank_n", 1'b0, vga_blank_n);
    check_bit("reset_raster hsync", 1'b0, vga_hsync);
    check_bit("reset_raster vsync", 1'b0, vga_vsync);
    fill_frame(1'b0);
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    for (int t = 0; t < 2; t++) begin
      start_test($sformatf("pixel_path_%0d", t));
      fill_frame(1'b0);
      send_frame(`FB_DEPTH, 1'b0);
      check_frame(cur_name);
      finish_test();
    end

    for (int t = 0; t < 2; t++) begin
      start_test($sformatf("highlight_%0d", t));
      fill_frame(1'b1);
      send_frame(`FB_DEPTH, 1'b0);
      check_frame(cur_name);
      finish_test();
    end

    // a strong cluster in one region with a little noise elsewhere
    start_test("class_left");
    fill_frame(1'b0);
    add_orange(7, 0, `LEFT_END);
    add_orange(2, `LEFT_END, `H_ACTIVE);
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    start_test("class_center");
    fill_frame(1'b0);
    add_orange(7, `LEFT_END, `RIGHT_START);
    add_orange(2, 0, `LEFT_END);
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    start_test("class_right");
    fill_frame(1'b0);
    add_orange(7, `RIGHT_START, `H_ACTIVE);
    add_orange(2, 0, `LEFT_END);
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    // three left against three right so left takes the tie
    start_test("class_tie");
    fill_frame(1'b0);
    for (int i = 0; i < 3; i++) begin
      model[i] = rand_orange();
      model[2 * `H_ACTIVE + `RIGHT_START + i] = rand_orange();
    end
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    start_test("class_random");
    fill_frame(1'b0);
    add_orange(12, 0, `H_ACTIVE);
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    // below the detection minimum
    start_test("class_sparse");
    fill_frame(1'b0);
    add_orange(`DETECT_MIN - 1, 0, `H_ACTIVE);
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    // partial junk load before vsync restarts a complete load
    start_test("restart_cut");
    fill_frame(1'b1);
    send_frame(70, 1'b1);
    send_frame(`FB_DEPTH, 1'b0);
    check_frame(cur_name);
    finish_test();

    // pixels beyond the buffer must not wrap onto the start
    start_test("overflow");
    fill_frame(1'b1);
    send_frame(`FB_DEPTH + 20, 1'b0);
    check_frame(cur_name);
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // hard limit on simulated time
  initial begin
    #(WATCHDOG_NS);
    $display("error: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the vision testbench with Verilator, pass only on the pass line in the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module vision_tb -o vision_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vision_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx '\*\*\* PASSED \*\*\*' "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== sim.f ====
+incdir+design
design/vision_pkg.sv
design/scan_timing.sv
design/ov7670_capture.sv
design/frame_buffer.sv
design/target_finder.sv
design/target_classifier.sv
design/vision_top.sv
dv/vision_tb.sv
